// File: Makefile
# Verilator lint and simulation of the niuCore testbench

VERILATOR ?= verilator
TOP       ?= niuCoreTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= STATUS: FAIL
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
logic/isaPkg.sv
logic/machinePkg.sv
logic/datapathIf.sv
logic/sequencer.sv
logic/fetchUnit.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/memoryUnit.sv
logic/niuCore.sv
tests/niuCore_assertions.sv
tests/niuCoreTb.sv

// File: logic/aluUnit.sv
`default_nettype none

module aluUnit
    import isaPkg::*;
(
    input  logic   clk,
    datapathIf.alu dp
);

    wordT a;
    wordT b;
    logic [4:0] shamt;

    always_ff @(posedge clk) begin
        if (dp.ldA) begin
            a <= dp.bus;
        end
        if (dp.ldB) begin
            b <= dp.bus;
        end
    end

    assign shamt = b[4:0];   // Shift amount from B

    always_comb begin
        case (dp.aluFunc)
            aluSub: dp.aluResult = a - b;
            aluAdd: dp.aluResult = a + b;
            aluMlt: dp.aluResult = a * b;          // Low word of product
            aluNot: dp.aluResult = ~a;
            aluAnd: dp.aluResult = a & b;
            aluOr:  dp.aluResult = a | b;
            aluXor: dp.aluResult = a ^ b;
            aluSul: dp.aluResult = a << shamt;
            aluSsl: dp.aluResult = a <<< shamt;
            aluSur: dp.aluResult = a >> shamt;
            aluSsr: dp.aluResult = wordT'($signed(a) >>> shamt);
            // Signed compares give 1 or 0
            aluEq:  dp.aluResult = wordT'(a == b);
            aluNeq: dp.aluResult = wordT'(a != b);
            aluLt:  dp.aluResult = wordT'($signed(a) < $signed(b));
            aluLeq: dp.aluResult = wordT'($signed(a) <= $signed(b));
            default: dp.aluResult = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/datapathIf.sv
`default_nettype none

interface datapathIf
    import isaPkg::*;
();
    wordT bus;                        // Shared internal bus

    logic ldPc;
    logic incPc;
    logic ldIr;
    logic wrReg;
    logic [regSelWidth-1:0] regSel;
    logic ldA;
    logic ldB;
    aluFuncT aluFunc;
    logic ldMar;
    logic wrMem;

    // Values sent back from the units
    wordT pc;
    wordT ir;
    wordT regData;
    wordT aluResult;
    wordT mdr;

    modport sequencer (
        output bus, ldPc, incPc, ldIr, wrReg, regSel, ldA, ldB, aluFunc, ldMar, wrMem,
        input  pc, ir, regData, aluResult, mdr
    );
    modport fetch (input bus, ldPc, incPc, ldIr, output pc, ir);
    modport regs (input bus, wrReg, regSel, output regData);
    modport alu (input bus, ldA, ldB, aluFunc, output aluResult);
    modport mem (input bus, ldMar, wrMem, output mdr);

endinterface

`default_nettype wire

// File: logic/fetchUnit.sv
`default_nettype none

module fetchUnit
    import isaPkg::*;
    import machinePkg::*;
#(
    parameter int imemWords = 2048
) (
    input  logic                         clk,
    input  logic                         reset,
    datapathIf.fetch                     dp,
    input  logic                         progWrite,
    input  logic [$clog2(imemWords)-1:0] progAddr,
    input  wordT                         progData
);

    localparam int addrBits  = $clog2(imemWords);
    localparam int byteShift = $clog2($bits(wordT) / 8);

    wordT imem [imemWords];
    logic [addrBits-1:0] pcIndex;

    assign pcIndex = dp.pc[byteShift +: addrBits];   // Word index of PC

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dp.pc <= pcStart;
        end else if (dp.ldPc) begin
            dp.pc <= dp.bus;
        end else if (dp.incPc) begin
            dp.pc <= dp.pc + wordT'(instrBytes);
        end
    end

    // Program load port and instruction register
    always_ff @(posedge clk) begin
        if (progWrite) begin
            imem[progAddr] <= progData;
        end
        if (dp.ldIr) begin
            dp.ir <= imem[pcIndex];
        end
    end

endmodule

`default_nettype wire

// File: logic/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef logic [31:0] wordT;

    localparam int opcodeWidth = 5;
    localparam int regSelWidth = 5;
    localparam int immWidth    = 17;

    // Low bit of each instruction field
    localparam int op1Lsb = 27;
    localparam int rxLsb  = 22;
    localparam int ryLsb  = 17;
    localparam int rzLsb  = 12;
    localparam int immLsb = 0;
    localparam int op2Lsb = 0;

    // Primary opcodes; immediate ALU codes match their ALU function codes
    typedef enum logic [opcodeWidth-1:0] {
        opAlu  = 5'b00000,
        opAddi = 5'b00001,
        opMlti = 5'b00010,
        opAndi = 5'b00101,
        opOri  = 5'b00110,
        opXori = 5'b00111,
        opSuli = 5'b01000,
        opSsli = 5'b01001,
        opSuri = 5'b01010,
        opSsri = 5'b01011,
        opLw   = 5'b10000,
        opSw   = 5'b10011,
        opBeq  = 5'b11000,
        opBne  = 5'b11001,
        opBlt  = 5'b11010,
        opBle  = 5'b11011,
        opJal  = 5'b11111
    } opcodeT;

    // Secondary codes, also used as the ALU select
    typedef enum logic [opcodeWidth-1:0] {
        aluSub = 5'b00000,
        aluAdd = 5'b00001,
        aluMlt = 5'b00010,
        aluNot = 5'b00100,
        aluAnd = 5'b00101,
        aluOr  = 5'b00110,
        aluXor = 5'b00111,
        aluSul = 5'b01000,
        aluSsl = 5'b01001,
        aluSur = 5'b01010,
        aluSsr = 5'b01011,
        aluEq  = 5'b10000,
        aluNeq = 5'b10001,
        aluLt  = 5'b10010,
        aluLeq = 5'b10011
    } aluFuncT;

endpackage

`default_nettype wire

// File: logic/machinePkg.sv
`default_nettype none

package machinePkg;

    import isaPkg::*;

    localparam int   instrBytes  = 4;            // PC step
    localparam wordT pcStart     = 32'h0000_0000;
    localparam wordT outPortAddr = 32'hFFFF_0020; // Output register location

    typedef enum logic [4:0] {
        fetch,
        decode,
        aluOperandB,
        aluOperandA,
        aluWrite,
        memBaseA,
        memOffsetB,
        memAddress,
        loadRead,
        loadWrite,
        storeWrite,
        branchA,
        branchB,
        branchTest,
        branchPcA,
        branchOffsetB,
        branchPcWrite,
        jumpLink,
        jumpTarget,
        halt
    } stateT;

    // Which unit drives the shared bus
    typedef enum logic [2:0] {
        srcNone,
        srcPc,
        srcRegister,
        srcMdr,
        srcImmediate,
        srcScaledImmediate,
        srcAlu
    } busSrcT;

endpackage

`default_nettype wire

// File: logic/memoryUnit.sv
`default_nettype none

module memoryUnit
    import isaPkg::*;
    import machinePkg::*;
#(
    parameter int dmemWords = 2048
) (
    input  logic   clk,
    input  logic   reset,
    datapathIf.mem dp,
    output wordT   outData,
    output logic   outWrite
);

    localparam int addrBits  = $clog2(dmemWords);
    localparam int byteShift = $clog2($bits(wordT) / 8);

    wordT dmem [dmemWords];
    wordT mar;
    logic [addrBits-1:0] marIndex;
    logic isOutPort;

    assign marIndex  = mar[byteShift +: addrBits];
    assign isOutPort = (mar == outPortAddr);

    always_ff @(posedge clk) begin
        if (dp.ldMar) begin
            mar <= dp.bus;
        end
        dp.mdr <= dmem[marIndex];      // Follows MAR every cycle
        if (dp.wrMem && !isOutPort) begin
            dmem[marIndex] <= dp.bus;
        end
    end

    // Memory-mapped output register
    always_ff @(posedge clk) begin
        if (dp.wrMem && isOutPort) begin
            outData <= dp.bus;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outWrite <= 1'b0;
        end else begin
            outWrite <= dp.wrMem && isOutPort;   // One-cycle pulse
        end
    end

endmodule

`default_nettype wire

// File: logic/niuCore.sv
`default_nettype none

module niuCore
    import isaPkg::*;
#(
    parameter int imemWords = 2048,
    parameter int dmemWords = 2048
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         progWrite,
    input  logic [$clog2(imemWords)-1:0] progAddr,
    input  wordT                         progData,
    output wordT                         outData,
    output logic                         outWrite,
    output logic                         halted
);

    datapathIf dp ();

    sequencer sequencerInst (
        .clk    (clk),
        .reset  (reset),
        .dp     (dp.sequencer),
        .halted (halted)
    );

    fetchUnit #(
        .imemWords (imemWords)
    ) fetchInst (
        .clk       (clk),
        .reset     (reset),
        .dp        (dp.fetch),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData)
    );

    registerFile registerInst (
        .clk (clk),
        .dp  (dp.regs)
    );

    aluUnit aluInst (
        .clk (clk),
        .dp  (dp.alu)
    );

    memoryUnit #(
        .dmemWords (dmemWords)
    ) memoryInst (
        .clk      (clk),
        .reset    (reset),
        .dp       (dp.mem),
        .outData  (outData),
        .outWrite (outWrite)
    );

endmodule

`default_nettype wire

// File: logic/registerFile.sv
`default_nettype none

module registerFile
    import isaPkg::*;
(
    input  logic    clk,
    datapathIf.regs dp
);

    localparam int numRegs = 2 ** regSelWidth;

    wordT regs [numRegs];

    // Single port, written from the bus
    always_ff @(posedge clk) begin
        if (dp.wrReg) begin
            regs[dp.regSel] <= dp.bus;
        end
    end

    assign dp.regData = regs[dp.regSel];

endmodule

`default_nettype wire

// File: logic/sequencer.sv
`default_nettype none

module sequencer
    import isaPkg::*;
    import machinePkg::*;
(
    input  logic         clk,
    input  logic         reset,
    datapathIf.sequencer dp,
    output logic         halted
);

    stateT   state;
    stateT   nextState;
    busSrcT  busSrc;
    opcodeT  op1;
    aluFuncT op2;
    logic [regSelWidth-1:0] rx;
    logic [regSelWidth-1:0] ry;
    logic [regSelWidth-1:0] rz;
    logic [immWidth-1:0]    imm;
    wordT    immExt;

    // Instruction fields
    assign op1 = opcodeT'(dp.ir[op1Lsb +: opcodeWidth]);
    assign op2 = aluFuncT'(dp.ir[op2Lsb +: opcodeWidth]);
    assign rx  = dp.ir[rxLsb +: regSelWidth];
    assign ry  = dp.ir[ryLsb +: regSelWidth];
    assign rz  = dp.ir[rzLsb +: regSelWidth];
    assign imm = dp.ir[immLsb +: immWidth];

    assign immExt = {{($bits(wordT) - immWidth){imm[immWidth-1]}}, imm};

    function automatic logic knownFunc(input aluFuncT f);
        case (f)
            aluSub, aluAdd, aluMlt, aluNot, aluAnd, aluOr, aluXor,
            aluSul, aluSsl, aluSur, aluSsr,
            aluEq, aluNeq, aluLt, aluLeq: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Immediate opcodes share their code with the ALU function
    function automatic aluFuncT immFunc(input opcodeT op);
        return aluFuncT'(op);
    endfunction

    function automatic aluFuncT branchFunc(input opcodeT op);
        case (op)
            opBeq:   return aluEq;
            opBne:   return aluNeq;
            opBlt:   return aluLt;
            default: return aluLeq;
        endcase
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= fetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState  = state;
        busSrc     = srcNone;
        dp.ldPc    = 1'b0;
        dp.incPc   = 1'b0;
        dp.ldIr    = 1'b0;
        dp.wrReg   = 1'b0;
        dp.regSel  = '0;
        dp.ldA     = 1'b0;
        dp.ldB     = 1'b0;
        dp.aluFunc = aluAdd;
        dp.ldMar   = 1'b0;
        dp.wrMem   = 1'b0;

        case (state)
            fetch: begin
                dp.ldIr   = 1'b1;
                dp.incPc  = 1'b1;
                nextState = decode;
            end
            decode: begin
                case (op1)
                    opAlu:  nextState = knownFunc(op2) ? aluOperandB : halt;
                    opAddi, opMlti, opAndi, opOri, opXori,
                    opSuli, opSsli, opSuri, opSsri: nextState = aluOperandB;
                    opLw, opSw: nextState = memBaseA;
                    opBeq, opBne, opBlt, opBle: nextState = branchA;
                    opJal:   nextState = jumpLink;
                    default: nextState = halt;   // Unknown opcode
                endcase
            end
            aluOperandB: begin
                if (op1 == opAlu) begin
                    dp.regSel = ry;
                    busSrc    = srcRegister;
                end else begin
                    busSrc = srcImmediate;
                end
                dp.ldB    = 1'b1;
                nextState = aluOperandA;
            end
            aluOperandA: begin
                dp.regSel = rx;
                busSrc    = srcRegister;
                dp.ldA    = 1'b1;
                nextState = aluWrite;
            end
            aluWrite: begin
                if (op1 == opAlu) begin
                    dp.aluFunc = op2;
                    dp.regSel  = rz;
                end else begin
                    dp.aluFunc = immFunc(op1);
                    dp.regSel  = ry;
                end
                busSrc    = srcAlu;
                dp.wrReg  = 1'b1;
                nextState = fetch;
            end
            memBaseA: begin
                dp.regSel = rx;
                busSrc    = srcRegister;
                dp.ldA    = 1'b1;
                nextState = memOffsetB;
            end
            memOffsetB: begin
                busSrc    = srcImmediate;
                dp.ldB    = 1'b1;
                nextState = memAddress;
            end
            memAddress: begin
                busSrc    = srcAlu;        // Base plus offset into MAR
                dp.ldMar  = 1'b1;
                nextState = (op1 == opLw) ? loadRead : storeWrite;
            end
            loadRead: begin
                nextState = loadWrite;     // MDR picks up the addressed word
            end
            loadWrite: begin
                dp.regSel = ry;
                busSrc    = srcMdr;
                dp.wrReg  = 1'b1;
                nextState = fetch;
            end
            storeWrite: begin
                dp.regSel = ry;
                busSrc    = srcRegister;
                dp.wrMem  = 1'b1;
                nextState = fetch;
            end
            branchA: begin
                dp.regSel = rx;
                busSrc    = srcRegister;
                dp.ldA    = 1'b1;
                nextState = branchB;
            end
            branchB: begin
                dp.regSel = ry;
                busSrc    = srcRegister;
                dp.ldB    = 1'b1;
                nextState = branchTest;
            end
            branchTest: begin
                dp.aluFunc = branchFunc(op1);
                nextState  = (dp.aluResult != '0) ? branchPcA : fetch;
            end
            branchPcA: begin
                busSrc    = srcPc;         // Already points past the branch
                dp.ldA    = 1'b1;
                nextState = branchOffsetB;
            end
            branchOffsetB: begin
                busSrc    = srcScaledImmediate;
                dp.ldB    = 1'b1;
                nextState = branchPcWrite;
            end
            branchPcWrite: begin
                busSrc    = srcAlu;
                dp.ldPc   = 1'b1;
                nextState = fetch;
            end
            jumpLink: begin
                dp.regSel = ry;
                busSrc    = srcPc;
                dp.wrReg  = 1'b1;
                nextState = jumpTarget;
            end
            jumpTarget: begin
                dp.regSel = rx;
                busSrc    = srcRegister;
                dp.ldPc   = 1'b1;
                nextState = fetch;
            end
            halt: nextState = halt;
            default: nextState = halt;
        endcase
    end

    // Bus multiplexer
    always_comb begin
        case (busSrc)
            srcPc:              dp.bus = dp.pc;
            srcRegister:        dp.bus = dp.regData;
            srcMdr:             dp.bus = dp.mdr;
            srcImmediate:       dp.bus = immExt;
            srcScaledImmediate: dp.bus = immExt * instrBytes;
            srcAlu:             dp.bus = dp.aluResult;
            default:            dp.bus = '0;
        endcase
    end

    assign halted = (state == halt);

endmodule

`default_nettype wire

// File: tests/niuCoreTb.sv
`default_nettype none

module niuCoreTb
    import isaPkg::*;
    import machinePkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int imemWords    = 2048;
    localparam int dmemWords    = 2048;
    localparam int progAddrBits = $clog2(imemWords);
    localparam int clkPeriod    = 8;
    localparam int bodyItems    = 60;
    localparam int windowSlots  = 8;
    localparam int jumpReg      = 29;
    localparam int zeroReg      = 30;     // Stays zero, base of the data window
    localparam int addrReg      = 31;     // Holds outPortAddr
    localparam logic [16:0] outPortImm = outPortAddr[16:0];   // Sign-extends to outPortAddr
    localparam wordT haltWord = 32'hE000_0000;                // Opcode 11100 is unused

    localparam logic [4:0] regFuncs [15] = '{aluSub, aluAdd, aluMlt, aluNot, aluAnd, aluOr,
        aluXor, aluSul, aluSsl, aluSur, aluSsr, aluEq, aluNeq, aluLt, aluLeq};
    localparam logic [4:0] immOps [9] = '{opAddi, opMlti, opAndi, opOri, opXori,
        opSuli, opSsli, opSuri, opSsri};
    localparam logic [4:0] branchOps [4] = '{opBeq, opBne, opBlt, opBle};

    logic clk;
    logic reset;
    logic progWrite;
    logic [progAddrBits-1:0] progAddr;
    wordT progData;
    wordT outData;
    logic outWrite;
    logic halted;

    logic [15:0] lfsr;
    wordT progWords[$];
    wordT expectedOut[$];
    int   expectedTotal;
    int   pulseCount;
    int   storedCount;
    logic storedSlot [windowSlots];

    niuCore #(
        .imemWords (imemWords),
        .dmemWords (dmemWords)
    ) DUT (
        .clk       (clk),
        .reset     (reset),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .outData   (outData),
        .outWrite  (outWrite),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11+1
            lfsr = {lfsr[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic wordT encodeReg(input logic [4:0] func, input logic [4:0] rx,
                                       input logic [4:0] ry, input logic [4:0] rz);
        return {5'b00000, rx, ry, rz, 7'b0000000, func};
    endfunction

    function automatic wordT encodeImm(input logic [4:0] op, input logic [4:0] rx,
                                       input logic [4:0] ry, input logic [16:0] imm);
        return {op, rx, ry, imm};
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input wordT actual, input wordT expected);
        if (actual !== expected) begin
            failRun($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                              $time, name, actual, expected));
        end
    endtask

    task automatic appendAlu(output logic [4:0] dest);
        logic [4:0] rx;
        logic [4:0] ry;
        int pick;
        rx   = 5'(randomBits(5));
        ry   = 5'(randomBits(5));
        dest = 5'(randomBits(5) % 30);        // Reserved registers are never written
        if (randomBits(1) == 1) begin
            pick = int'(randomBits(4) % 15);
            progWords.push_back(encodeReg(regFuncs[pick], rx, ry, dest));
        end else begin
            pick = int'(randomBits(4) % 9);
            progWords.push_back(encodeImm(immOps[pick], rx, dest, 17'(randomBits(17))));
        end
    endtask

    task automatic outputStore(input logic [4:0] src);
        progWords.push_back(encodeImm(opSw, 5'(addrReg), src, 17'd0));
    endtask

    task automatic dataStore();
        int slot;
        logic [4:0] src;
        slot = int'(randomBits(3));
        src  = 5'(randomBits(5));
        storedSlot[slot] = 1'b1;
        storedCount++;
        progWords.push_back(encodeImm(opSw, 5'(zeroReg), src, 17'(slot * 4)));
    endtask

    // Load from a slot written earlier, then send it out
    task automatic dataLoad();
        int slot;
        logic [4:0] dest;
        if (storedCount == 0) begin
            dataStore();
        end
        slot = int'(randomBits(3));
        while (!storedSlot[slot]) begin
            slot = (slot + 1) % windowSlots;
        end
        dest = 5'(randomBits(5) % 30);
        progWords.push_back(encodeImm(opLw, 5'(zeroReg), dest, 17'(slot * 4)));
        outputStore(dest);
    endtask

    // Skipped code holds no data stores, so every load stays defined
    task automatic shadowFiller();
        logic [4:0] dest;
        if (randomBits(1) == 1) begin
            appendAlu(dest);
        end else begin
            outputStore(5'(randomBits(5)));
        end
    endtask

    task automatic forwardBranch();
        int skip;
        int pick;
        logic [4:0] rx;
        logic [4:0] ry;
        skip = 1 + int'(randomBits(2) % 3);
        pick = int'(randomBits(2));
        rx   = 5'(randomBits(5));
        ry   = 5'(randomBits(5));
        progWords.push_back(encodeImm(branchOps[pick], rx, ry, 17'(skip)));
        repeat (skip) shadowFiller();
    endtask

    task automatic jumpAndLink();
        int skip;
        int target;
        logic [4:0] link;
        skip   = 1 + int'(randomBits(2) % 3);
        link   = 5'(randomBits(5) % 29);     // Never the target register
        target = progWords.size() + 2 + skip;
        progWords.push_back(encodeImm(opAddi, 5'(zeroReg), 5'(jumpReg), 17'(target * instrBytes)));
        progWords.push_back(encodeImm(opJal, 5'(jumpReg), link, 17'd0));
        repeat (skip) shadowFiller();
        outputStore(link);                   // Link value becomes visible
    endtask

    task automatic buildProgram();
        int choice;
        logic [4:0] dest;
        for (int r = 0; r < 32; r++) begin
            progWords.push_back(encodeImm(opAndi, 5'(r), 5'(r), 17'd0));
        end
        progWords.push_back(encodeImm(opAddi, 5'(zeroReg), 5'(addrReg), outPortImm));
        for (int item = 0; item < bodyItems; item++) begin
            if (item == bodyItems / 2) begin
                jumpAndLink();
            end
            choice = int'(randomBits(3));
            case (choice)
                0, 1: appendAlu(dest);
                2: begin
                    appendAlu(dest);
                    outputStore(dest);
                end
                3: dataStore();
                4: dataLoad();
                5, 6: outputStore(5'(randomBits(5)));
                default: forwardBranch();
            endcase
        end
        progWords.push_back(haltWord);
    endtask

    function automatic wordT aluModel(input logic [4:0] func, input wordT a, input wordT b);
        case (func)
            aluSub: return a - b;
            aluAdd: return a + b;
            aluMlt: return a * b;
            aluNot: return ~a;
            aluAnd: return a & b;
            aluOr:  return a | b;
            aluXor: return a ^ b;
            aluSul, aluSsl: return a << b[4:0];
            aluSur: return a >> b[4:0];
            aluSsr: return wordT'($signed(a) >>> b[4:0]);
            aluEq:  return {31'd0, a == b};
            aluNeq: return {31'd0, a != b};
            aluLt:  return {31'd0, $signed(a) < $signed(b)};
            aluLeq: return {31'd0, $signed(a) <= $signed(b)};
            default: return '0;
        endcase
    endfunction

    function automatic logic [4:0] immToAluFunc(input logic [4:0] op);
        case (op)
            opAddi: return aluAdd;
            opMlti: return aluMlt;
            opAndi: return aluAnd;
            opOri:  return aluOr;
            opXori: return aluXor;
            opSuli: return aluSul;
            opSsli: return aluSsl;
            opSuri: return aluSur;
            default: return aluSsr;
        endcase
    endfunction

    // Instruction-set model, collects the expected output writes
    task automatic runModel();
        wordT regs [32];
        wordT dmemModel [wordT];
        wordT pc;
        wordT instr;
        wordT immExt;
        wordT addr;
        logic [4:0] op;
        logic [4:0] rx;
        logic [4:0] ry;
        logic [4:0] rz;
        logic taken;
        logic running;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc      = pcStart;
        running = 1'b1;
        while (running) begin
            instr  = progWords[pc / instrBytes];
            op     = instr[31:27];
            rx     = instr[26:22];
            ry     = instr[21:17];
            rz     = instr[16:12];
            immExt = {{15{instr[16]}}, instr[16:0]};
            pc     = pc + instrBytes;
            case (op)
                opAlu: regs[rz] = aluModel(instr[4:0], regs[rx], regs[ry]);
                opAddi, opMlti, opAndi, opOri, opXori, opSuli, opSsli, opSuri, opSsri:
                    regs[ry] = aluModel(immToAluFunc(op), regs[rx], immExt);
                opLw: regs[ry] = dmemModel[(regs[rx] + immExt) >> 2];
                opSw: begin
                    addr = regs[rx] + immExt;
                    if (addr == outPortAddr) begin
                        expectedOut.push_back(regs[ry]);
                    end else begin
                        dmemModel[addr >> 2] = regs[ry];
                    end
                end
                opBeq, opBne, opBlt, opBle: begin
                    case (op)
                        opBeq:   taken = (regs[rx] == regs[ry]);
                        opBne:   taken = (regs[rx] != regs[ry]);
                        opBlt:   taken = ($signed(regs[rx]) < $signed(regs[ry]));
                        default: taken = ($signed(regs[rx]) <= $signed(regs[ry]));
                    endcase
                    if (taken) begin
                        pc = pc + immExt * instrBytes;
                    end
                end
                opJal: begin
                    addr     = regs[rx];
                    regs[ry] = pc;
                    pc       = addr;
                end
                default: running = 1'b0;      // Unknown opcode ends the program
            endcase
        end
    endtask

    task automatic watchdog(input int limit);
        repeat (limit) @(posedge clk);
        failRun($sformatf("Timeout: core did not halt within %0d cycles", limit));
    endtask

    task automatic checkOutput();
        wordT expected;
        if (expectedOut.size() == 0) begin
            failRun("Output write seen after the model ran out of values");
        end else begin
            expected = expectedOut.pop_front();
            checkValue("outData", outData, expected);
            pulseCount++;
        end
    endtask

    initial begin
        reset       = 1'b1;
        progWrite   = 1'b0;
        progAddr    = '0;
        progData    = '0;
        lfsr        = 16'd3307;
        pulseCount  = 0;
        storedCount = 0;
        foreach (storedSlot[i]) begin
            storedSlot[i] = 1'b0;
        end
        buildProgram();
        runModel();
        expectedTotal = expectedOut.size();
        $display("Program of %0d words, %0d output writes expected",
                 progWords.size(), expectedTotal);

        // Load time, then at most 8 cycles per instruction
        fork
            watchdog(progWords.size() * 9 + 200);
        join_none

        for (int i = 0; i < progWords.size(); i++) begin
            @(negedge clk);
            progWrite = 1'b1;
            progAddr  = progAddrBits'(i);
            progData  = progWords[i];
        end
        @(negedge clk);
        progWrite = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        checkValue("halted", wordT'(halted), 32'd0);
        checkValue("outWrite", wordT'(outWrite), 32'd0);
        while (halted !== 1'b1) begin
            if (outWrite === 1'b1) begin
                checkOutput();
            end
            @(negedge clk);
        end

        repeat (5) begin
            @(negedge clk);
            checkValue("halted", wordT'(halted), 32'd1);
            checkValue("outWrite", wordT'(outWrite), 32'd0);
        end

        if (pulseCount == expectedTotal && expectedOut.size() == 0) begin
            $display("Saw %0d output writes", pulseCount);
            $display("STATUS: PASS");
            $finish;
        end else begin
            failRun($sformatf("Wrong number of output writes: saw %0d, model has %0d",
                              pulseCount, expectedTotal));
        end
    end

endmodule

`default_nettype wire

// File: tests/niuCore_assertions.sv
`default_nettype none

module niuCoreAssertions (
    input logic clk,
    input logic reset,
    input logic outWrite,
    input logic halted
);
    timeunit 1ns;
    timeprecision 1ps;

    // Both marks come out of reset low
    resetClearsOutputs: assert property (@(posedge clk) reset |=> !outWrite && !halted)
        else $error("outWrite or halted high right after reset");

    singlePulse: assert property (@(posedge clk) disable iff (reset) outWrite |=> !outWrite)
        else $error("outWrite high for two cycles in a row");

    // Halt is a sink state
    haltHolds: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else $error("halted dropped without a reset");

endmodule

bind niuCore niuCoreAssertions assertionsInst (
    .clk      (clk),
    .reset    (reset),
    .outWrite (outWrite),
    .halted   (halted)
);

`default_nettype wire
